// ==== src/eth_csr_pkg.sv ====
// Register map for the management block; byte offsets must be word aligned to decode
`default_nettype none

package eth_csr_pkg;

    localparam int CSR_ADDR_W = 16;
    localparam int CSR_DATA_W = 32;

    // Register offsets
    localparam logic [CSR_ADDR_W-1:0] REG_STATUS     = 16'h0000;
    localparam logic [CSR_ADDR_W-1:0] REG_INT_ENABLE = 16'h0008;
    localparam logic [CSR_ADDR_W-1:0] REG_INT_STATUS = 16'h000C;
    localparam logic [CSR_ADDR_W-1:0] REG_CONTROL    = 16'h0020;
    localparam logic [CSR_ADDR_W-1:0] REG_MDIO_TX    = 16'h0024;
    localparam logic [CSR_ADDR_W-1:0] REG_MDIO_RX    = 16'h0028;

    // Interrupt status bit positions
    localparam int INT_MDIO_IDLE_BIT = 18;
    localparam int INT_PHY_BIT       = 19;

    localparam int CTRL_PHY_RUN_BIT = 2;

    localparam int STATUS_W = 16;

    typedef logic [CSR_DATA_W-1:0] csr_word_t;

endpackage

`default_nettype wire

// ==== src/mdio_pkg.sv ====
// MDIO frame layout and divider are fixed at build time; the preamble is always 32 ones
`default_nettype none

package mdio_pkg;

    // Half period of the management clock is MDIO_DIV+1 clocks
    localparam int MDIO_DIV   = 24;
    localparam int MDIO_DIV_W = $clog2(MDIO_DIV + 1);

    localparam int MDIO_FRAME_W        = 32;
    localparam int MDIO_CNT_W          = 6;
    localparam int MDIO_READ_OP_BIT    = 29;
    localparam int MDIO_TURNAROUND_CNT = 46;

    localparam int MDIO_SYNC_STAGES = 3;

    typedef logic [MDIO_FRAME_W-1:0] mdio_frame_t;

endpackage

`default_nettype wire

// ==== src/mdio_req_if.sv ====
// One MDIO request at a time; start is a level held until done is seen high
`timescale 1ns/1ps
`default_nettype none

interface mdio_req_if
    import eth_csr_pkg::*, mdio_pkg::*;
();

    logic        start;
    mdio_frame_t frame;
    logic        done;
    // Valid while done is high
    csr_word_t   rx_data;

    modport csr (
        output start,
        output frame,
        input  done,
        input  rx_data
    );

    modport engine (
        input  start,
        input  frame,
        output done,
        output rx_data
    );

endinterface

`default_nettype wire

// ==== src/eth_mgmt_regs.sv ====
// One outstanding AXI4-Lite read and write, responses always OKAY, MDIO_TX writes dropped if busy
`timescale 1ns/1ps
`default_nettype none

module eth_mgmt_regs
    import eth_csr_pkg::*, mdio_pkg::*;
(
    input  wire                  clock,
    input  wire                  reset,
    input  wire [CSR_ADDR_W-1:0] s_axi_awaddr_i,
    input  wire                  s_axi_awvalid_i,
    output logic                 s_axi_awready_o,
    input  wire [CSR_DATA_W-1:0] s_axi_wdata_i,
    input  wire                  s_axi_wvalid_i,
    output logic                 s_axi_wready_o,
    output logic [1:0]           s_axi_bresp_o,
    output logic                 s_axi_bvalid_o,
    input  wire                  s_axi_bready_i,
    input  wire [CSR_ADDR_W-1:0] s_axi_araddr_i,
    input  wire                  s_axi_arvalid_i,
    output logic                 s_axi_arready_o,
    output csr_word_t            s_axi_rdata_o,
    output logic [1:0]           s_axi_rresp_o,
    output logic                 s_axi_rvalid_o,
    input  wire                  s_axi_rready_i,
    input  wire [STATUS_W-1:0]   status_vector_i,
    input  wire                  mdio_int_i,
    output logic                 interrupt_o,
    output logic                 phy_reset_o,
    mdio_req_if.csr              req
);

    logic                        rd_req;
    logic [1:0]                  wr_req;
    logic [CSR_ADDR_W-1:0]       rd_addr;
    logic [CSR_ADDR_W-1:0]       wr_addr;
    csr_word_t                   wr_data;
    csr_word_t                   rd_word;
    csr_word_t                   int_enable;
    csr_word_t                   int_status;
    mdio_frame_t                 mdio_tx;
    logic                        phy_run;
    logic                        mdio_busy;
    logic [MDIO_SYNC_STAGES-1:0] phy_int_sync;

    assign s_axi_arready_o = !rd_req && !s_axi_rvalid_o;
    assign s_axi_awready_o = !wr_req[0] && !s_axi_bvalid_o;
    assign s_axi_wready_o  = !wr_req[1] && !s_axi_bvalid_o;
    assign s_axi_rresp_o   = 2'b00;
    assign s_axi_bresp_o   = 2'b00;

    assign mdio_busy   = req.start || req.done;
    assign req.frame   = mdio_tx;
    assign phy_reset_o = !phy_run;

    always_comb begin
        int_status = '0;
        int_status[STATUS_W-1:0] = status_vector_i;
        int_status[INT_MDIO_IDLE_BIT] = !mdio_busy;
        int_status[INT_PHY_BIT] = phy_int_sync[MDIO_SYNC_STAGES-1];
    end

    assign interrupt_o = |(int_enable & int_status);

    always_comb begin
        rd_word = '0;
        case (rd_addr)
            REG_STATUS:     rd_word[STATUS_W-1:0] = status_vector_i;
            REG_INT_ENABLE: rd_word = int_enable;
            REG_INT_STATUS: rd_word = int_status;
            REG_CONTROL:    rd_word[CTRL_PHY_RUN_BIT] = phy_run;
            REG_MDIO_TX:    rd_word = mdio_tx;
            REG_MDIO_RX:    rd_word = req.rx_data;
            default:        rd_word = '0;
        endcase
    end

    // PHY interrupt crosses in from the pin
    always_ff @(posedge clock) begin
        if (reset) begin
            phy_int_sync <= '0;
        end else begin
            phy_int_sync <= {phy_int_sync[MDIO_SYNC_STAGES-2:0], mdio_int_i};
        end
    end

    always_ff @(posedge clock) begin
        if (s_axi_arready_o && s_axi_arvalid_i) begin
            rd_addr <= s_axi_araddr_i;
        end
        if (!s_axi_rvalid_o && rd_req) begin
            s_axi_rdata_o <= rd_word;
        end
        if (s_axi_awready_o && s_axi_awvalid_i) begin
            wr_addr <= s_axi_awaddr_i;
        end
        if (s_axi_wready_o && s_axi_wvalid_i) begin
            wr_data <= s_axi_wdata_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_req         <= 1'b0;
            s_axi_rvalid_o <= 1'b0;
        end else begin
            if (s_axi_arready_o && s_axi_arvalid_i) begin
                rd_req <= 1'b1;
            end
            if (s_axi_rvalid_o && s_axi_rready_i) begin
                s_axi_rvalid_o <= 1'b0;
            end else if (!s_axi_rvalid_o && rd_req) begin
                s_axi_rvalid_o <= 1'b1;
                rd_req         <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_req         <= 2'b00;
            s_axi_bvalid_o <= 1'b0;
            int_enable     <= '0;
            phy_run        <= 1'b0;
            mdio_tx        <= '0;
            req.start      <= 1'b0;
        end else begin
            if (s_axi_awready_o && s_axi_awvalid_i) begin
                wr_req[0] <= 1'b1;
            end
            if (s_axi_wready_o && s_axi_wvalid_i) begin
                wr_req[1] <= 1'b1;
            end
            if (s_axi_bvalid_o && s_axi_bready_i) begin
                s_axi_bvalid_o <= 1'b0;
            end else if (!s_axi_bvalid_o && wr_req == 2'b11) begin
                case (wr_addr)
                    REG_INT_ENABLE: int_enable <= wr_data;
                    REG_CONTROL:    phy_run <= wr_data[CTRL_PHY_RUN_BIT];
                    REG_MDIO_TX: begin
                        if (!mdio_busy) begin
                            mdio_tx   <= wr_data;
                            req.start <= 1'b1;
                        end
                    end
                    default: ;
                endcase
                s_axi_bvalid_o <= 1'b1;
                wr_req         <= 2'b00;
            end
            // Engine saw the request through
            if (req.start && req.done) begin
                req.start <= 1'b0;
            end
        end
    end

    rdata_hold_a: assert property (@(posedge clock) disable iff (reset)
        s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o));

    start_after_done_a: assert property (@(posedge clock) disable iff (reset)
        $rose(req.start) |-> !req.done);

endmodule

`default_nettype wire

// ==== src/mdio_master.sv ====
// Management clock is clock/(2*(MDIO_DIV+1)); read frames release the line from bit 46 on
`timescale 1ns/1ps
`default_nettype none

module mdio_master
    import mdio_pkg::*;
(
    input  wire        clock,
    input  wire        reset,
    mdio_req_if.engine req,
    input  wire        mdio_i,
    output logic       mdio_clock_o,
    output logic       mdio_o,
    output logic       mdio_oe_o
);

    logic                  busy;
    logic [MDIO_CNT_W-1:0] bit_cnt;
    logic [MDIO_CNT_W-1:0] next_cnt;
    logic [MDIO_DIV_W-1:0] div_cnt;
    logic [1:0]            next_setup;
    logic                  rise;
    logic                  sample_en;

    // Output enable and line value for one bit slot
    function automatic logic [1:0] line_setup(input logic [MDIO_CNT_W-1:0] cnt,
                                              input mdio_frame_t frame);
        logic release_line;
        if (!cnt[MDIO_CNT_W-1]) begin
            return 2'b11;
        end
        release_line = frame[MDIO_READ_OP_BIT] && (cnt >= MDIO_TURNAROUND_CNT);
        return {!release_line, frame[~cnt[MDIO_CNT_W-2:0]]};
    endfunction

    assign next_cnt   = bit_cnt + 1'b1;
    assign next_setup = line_setup(next_cnt, req.frame);
    assign rise       = busy && !req.done && div_cnt == '0 && !mdio_clock_o;
    // Returned data only in the frame half
    assign sample_en  = rise && bit_cnt[MDIO_CNT_W-1];

    always_ff @(posedge clock) begin
        if (reset || !req.start) begin
            busy         <= 1'b0;
            req.done     <= 1'b0;
            bit_cnt      <= '0;
            div_cnt      <= MDIO_DIV_W'(MDIO_DIV);
            mdio_clock_o <= 1'b0;
            mdio_o       <= 1'b1;
            mdio_oe_o    <= 1'b0;
        end else if (req.done) begin
            // Hold until start drops
        end else if (!busy) begin
            // First preamble bit goes out with the clock low
            busy      <= 1'b1;
            mdio_o    <= 1'b1;
            mdio_oe_o <= 1'b1;
        end else if (div_cnt != '0) begin
            div_cnt <= div_cnt - 1'b1;
        end else begin
            div_cnt <= MDIO_DIV_W'(MDIO_DIV);
            if (!mdio_clock_o) begin
                mdio_clock_o <= 1'b1;
            end else if (&bit_cnt) begin
                mdio_clock_o <= 1'b0;
                busy         <= 1'b0;
                req.done     <= 1'b1;
                mdio_o       <= 1'b1;
                mdio_oe_o    <= 1'b0;
            end else begin
                // Next bit changes with the falling edge
                mdio_clock_o        <= 1'b0;
                bit_cnt             <= next_cnt;
                {mdio_oe_o, mdio_o} <= next_setup;
            end
        end
    end

    // MSB first, kept until the next frame overwrites it
    always_ff @(posedge clock) begin
        if (reset) begin
            req.rx_data <= '0;
        end else if (sample_en) begin
            req.rx_data[~bit_cnt[MDIO_CNT_W-2:0]] <= mdio_i;
        end
    end

    oe_release_a: assert property (@(posedge clock) disable iff (reset)
        busy && !mdio_oe_o |->
            req.frame[MDIO_READ_OP_BIT] && bit_cnt >= MDIO_TURNAROUND_CNT);

    frame_stable_a: assert property (@(posedge clock) disable iff (reset)
        req.start |=> !req.start || $stable(req.frame));

endmodule

`default_nettype wire

// ==== src/eth_mgmt_top.sv ====
// Management top; MDIO data is split into three pins for an external tri-state buffer
`timescale 1ns/1ps
`default_nettype none

module eth_mgmt_top
    import eth_csr_pkg::*;
(
    input  wire                  clock,
    input  wire                  reset,
    input  wire [CSR_ADDR_W-1:0] s_axi_awaddr_i,
    input  wire                  s_axi_awvalid_i,
    output wire                  s_axi_awready_o,
    input  wire [CSR_DATA_W-1:0] s_axi_wdata_i,
    input  wire                  s_axi_wvalid_i,
    output wire                  s_axi_wready_o,
    output wire [1:0]            s_axi_bresp_o,
    output wire                  s_axi_bvalid_o,
    input  wire                  s_axi_bready_i,
    input  wire [CSR_ADDR_W-1:0] s_axi_araddr_i,
    input  wire                  s_axi_arvalid_i,
    output wire                  s_axi_arready_o,
    output wire [CSR_DATA_W-1:0] s_axi_rdata_o,
    output wire [1:0]            s_axi_rresp_o,
    output wire                  s_axi_rvalid_o,
    input  wire                  s_axi_rready_i,
    input  wire [STATUS_W-1:0]   status_vector_i,
    input  wire                  mdio_int_i,
    input  wire                  mdio_i,
    output wire                  interrupt_o,
    output wire                  phy_reset_o,
    output wire                  mdio_clock_o,
    output wire                  mdio_o,
    output wire                  mdio_oe_o
);

    mdio_req_if req_if ();

    eth_mgmt_regs eth_mgmt_regs_inst (
        .clock           (clock),
        .reset           (reset),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .status_vector_i (status_vector_i),
        .mdio_int_i      (mdio_int_i),
        .interrupt_o     (interrupt_o),
        .phy_reset_o     (phy_reset_o),
        .req             (req_if.csr)
    );

    mdio_master mdio_master_inst (
        .clock        (clock),
        .reset        (reset),
        .req          (req_if.engine),
        .mdio_i       (mdio_i),
        .mdio_clock_o (mdio_clock_o),
        .mdio_o       (mdio_o),
        .mdio_oe_o    (mdio_oe_o)
    );

endmodule

`default_nettype wire

// ==== sim/mdio_phy_model.sv ====
// Behavioral PHY that records one frame at a time; pulse clear_i between frames
`timescale 1ns/1ps
`default_nettype none

module mdio_phy_model
    import mdio_pkg::*;
(
    input  wire                         mdio_clock_i,
    input  wire                         mdio_o_i,
    input  wire                         mdio_oe_i,
    input  wire                         clear_i,
    output logic                        line_o,
    output logic [2*MDIO_FRAME_W-1:0]   line_rec_o,
    output logic [2*MDIO_FRAME_W-1:0]   oe_rec_o,
    output mdio_frame_t                 driven_o,
    output logic [7:0]                  bit_count_o
);

    logic [31:0] lfsr_state = 32'h46f8_e066;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    assign line_o = mdio_oe_i ? mdio_o_i : lfsr_state[0];

    // New random bit set up while the clock is low
    always @(negedge mdio_clock_i) begin
        lfsr_state <= lfsr_step(lfsr_state);
    end

    // First recorded bit ends up in the MSB
    always @(posedge mdio_clock_i or posedge clear_i) begin
        if (clear_i) begin
            line_rec_o  <= '0;
            oe_rec_o    <= '0;
            driven_o    <= '0;
            bit_count_o <= '0;
        end else if (bit_count_o < 2 * MDIO_FRAME_W) begin
            line_rec_o  <= {line_rec_o[2*MDIO_FRAME_W-2:0], line_o};
            oe_rec_o    <= {oe_rec_o[2*MDIO_FRAME_W-2:0], mdio_oe_i};
            bit_count_o <= bit_count_o + 1'b1;
            if (!mdio_oe_i) begin
                driven_o <= {driven_o[MDIO_FRAME_W-2:0], lfsr_state[0]};
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_eth_mgmt.sv ====
// Needs concurrent assertion support; run length bounded by a watchdog of about three frames
`timescale 1ns/1ps
`default_nettype none

module tb_eth_mgmt
    import eth_csr_pkg::*, mdio_pkg::*;
();

    localparam int WATCHDOG_CYCLES = 3 * 64 * 2 * (MDIO_DIV + 1) + 2000;

    logic                  clock = 1'b0;
    logic                  reset;
    logic [CSR_ADDR_W-1:0] awaddr;
    logic                  awvalid;
    csr_word_t             wdata;
    logic                  wvalid;
    logic                  bready;
    logic [CSR_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  rready;
    logic [STATUS_W-1:0]   status_vector;
    logic                  mdio_int;
    logic                  model_clear;
    wire                   awready;
    wire                   wready;
    wire  [1:0]            bresp;
    wire                   bvalid;
    wire                   arready;
    wire  [CSR_DATA_W-1:0] rdata;
    wire  [1:0]            rresp;
    wire                   rvalid;
    wire                   interrupt;
    wire                   phy_reset;
    wire                   mdio_clock;
    wire                   mdio_out;
    wire                   mdio_oe;
    wire                   mdio_line;
    wire  [63:0]           line_rec;
    wire  [63:0]           oe_rec;
    wire  [31:0]           driven;
    wire  [7:0]            bit_count;

    int          errors = 0;
    int          test_start_errors;
    int          tests_passed = 0;
    int          tests_failed = 0;
    string       test_name;
    logic        write_frame_chk = 1'b0;
    logic [31:0] lfsr = 32'h46f8_e066;
    logic [31:0] rand_value;
    csr_word_t   data;
    mdio_frame_t frame;

    always #5 clock = !clock;

    eth_mgmt_top eth_mgmt_top_inst (
        .clock           (clock),
        .reset           (reset),
        .s_axi_awaddr_i  (awaddr),
        .s_axi_awvalid_i (awvalid),
        .s_axi_awready_o (awready),
        .s_axi_wdata_i   (wdata),
        .s_axi_wvalid_i  (wvalid),
        .s_axi_wready_o  (wready),
        .s_axi_bresp_o   (bresp),
        .s_axi_bvalid_o  (bvalid),
        .s_axi_bready_i  (bready),
        .s_axi_araddr_i  (araddr),
        .s_axi_arvalid_i (arvalid),
        .s_axi_arready_o (arready),
        .s_axi_rdata_o   (rdata),
        .s_axi_rresp_o   (rresp),
        .s_axi_rvalid_o  (rvalid),
        .s_axi_rready_i  (rready),
        .status_vector_i (status_vector),
        .mdio_int_i      (mdio_int),
        .mdio_i          (mdio_line),
        .interrupt_o     (interrupt),
        .phy_reset_o     (phy_reset),
        .mdio_clock_o    (mdio_clock),
        .mdio_o          (mdio_out),
        .mdio_oe_o       (mdio_oe)
    );

    mdio_phy_model phy_model_inst (
        .mdio_clock_i (mdio_clock),
        .mdio_o_i     (mdio_out),
        .mdio_oe_i    (mdio_oe),
        .clear_i      (model_clear),
        .line_o       (mdio_line),
        .line_rec_o   (line_rec),
        .oe_rec_o     (oe_rec),
        .driven_o     (driven),
        .bit_count_o  (bit_count)
    );

    rvalid_hold_a: assert property (@(posedge clock) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            $display("read data valid dropped or read data changed while ready was low");
            errors++;
        end

    okay_resp_a: assert property (@(posedge clock) disable iff (reset)
        !(bvalid && bresp != 2'b00) && !(rvalid && rresp != 2'b00))
        else begin
            $display("a bus response other than OKAY was returned");
            errors++;
        end

    write_oe_a: assert property (@(posedge clock) disable iff (reset)
        write_frame_chk && mdio_clock |-> mdio_oe)
        else begin
            $display("MDIO line was released during a write frame");
            errors++;
        end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_random(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
        else begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_start_errors) begin
            $display("test %s: ok", test_name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", test_name, errors - test_start_errors);
            tests_failed++;
        end
    endtask

    task automatic axi_write(input logic [CSR_ADDR_W-1:0] addr, input csr_word_t value);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= value;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        while (!(aw_done && w_done)) begin
            @(posedge clock);
            if (!aw_done && awready) begin
                aw_done = 1'b1;
                awvalid <= 1'b0;
            end
            if (!w_done && wready) begin
                w_done = 1'b1;
                wvalid <= 1'b0;
            end
        end
        do begin
            @(posedge clock);
        end while (!bvalid);
        bready <= 1'b0;
        check_value("bresp", 2'b00, bresp);
    endtask

    task automatic axi_read(input logic [CSR_ADDR_W-1:0] addr, output csr_word_t value,
                            input int hold);
        araddr  <= addr;
        arvalid <= 1'b1;
        do begin
            @(posedge clock);
        end while (!arready);
        arvalid <= 1'b0;
        do begin
            @(posedge clock);
        end while (!rvalid);
        value = rdata;
        // Ready withheld for a while
        repeat (hold) @(posedge clock);
        rready <= 1'b1;
        @(posedge clock);
        rready <= 1'b0;
        check_value("rresp", 2'b00, rresp);
    endtask

    task automatic wait_mdio_idle();
        csr_word_t status;
        do begin
            axi_read(REG_INT_STATUS, status, 0);
        end while (!status[INT_MDIO_IDLE_BIT]);
    endtask

    task automatic wait_interrupt(input logic level);
        int cycles;
        cycles = 0;
        while (interrupt !== level && cycles < 16) begin
            @(posedge clock);
            cycles++;
        end
    endtask

    task automatic clear_model();
        model_clear <= 1'b1;
        @(posedge clock);
        model_clear <= 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        mdio_int = 1'b0;
        model_clear = 1'b0;
        take_random(STATUS_W, rand_value);
        status_vector = rand_value[STATUS_W-1:0];
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);

        begin_test("reset_state");
        check_value("interrupt_o", 1'b0, interrupt);
        check_value("phy_reset_o", 1'b1, phy_reset);
        check_value("mdio_clock_o", 1'b0, mdio_clock);
        check_value("mdio_oe_o", 1'b0, mdio_oe);
        axi_read(REG_INT_ENABLE, data, 0);
        check_value("int_enable", 32'h0, data);
        axi_read(REG_INT_STATUS, data, 0);
        check_value("idle bit", 1'b1, data[INT_MDIO_IDLE_BIT]);
        end_test();

        begin_test("registers");
        take_random(STATUS_W, rand_value);
        status_vector <= rand_value[STATUS_W-1:0];
        axi_read(REG_STATUS, data, 0);
        check_value("status", {16'h0, rand_value[15:0]}, data);
        axi_write(REG_INT_ENABLE, 32'h0000_5a5a);
        axi_read(REG_INT_ENABLE, data, 3);
        check_value("int_enable", 32'h0000_5a5a, data);
        axi_write(REG_INT_ENABLE, 32'h0);
        axi_write(REG_CONTROL, 32'h1 << CTRL_PHY_RUN_BIT);
        check_value("phy_reset_o", 1'b0, phy_reset);
        axi_read(16'h0100, data, 4);
        check_value("unmapped", 32'h0, data);
        end_test();

        begin_test("mdio_write");
        frame = 32'h5086_1234;
        clear_model();
        write_frame_chk <= 1'b1;
        axi_write(REG_MDIO_TX, frame);
        axi_read(REG_INT_STATUS, data, 0);
        check_value("busy", 1'b0, data[INT_MDIO_IDLE_BIT]);
        wait_mdio_idle();
        write_frame_chk <= 1'b0;
        check_value("bit count", 64, bit_count);
        check_value("preamble", 32'hffff_ffff, line_rec[63:32]);
        check_value("frame bits", frame, line_rec[31:0]);
        check_value("output enable", 64'hffff_ffff_ffff_ffff, oe_rec);
        axi_read(REG_INT_STATUS, data, 0);
        check_value("idle bit", 1'b1, data[INT_MDIO_IDLE_BIT]);
        end_test();

        begin_test("mdio_read");
        frame = 32'h6086_0000;
        clear_model();
        axi_write(REG_MDIO_TX, frame);
        wait_mdio_idle();
        check_value("bit count", 64, bit_count);
        // Released from recorded bit 46 on
        check_value("output enable", 64'hffff_ffff_fffc_0000, oe_rec);
        axi_read(REG_MDIO_RX, data, 0);
        check_value("rx line", line_rec[31:0], data);
        check_value("rx data", driven[15:0], data[15:0]);
        end_test();

        begin_test("interrupts");
        axi_write(REG_INT_ENABLE, 32'h1 << INT_MDIO_IDLE_BIT);
        check_value("idle irq", 1'b1, interrupt);
        axi_write(REG_MDIO_TX, 32'h5000_0000);
        check_value("busy irq", 1'b0, interrupt);
        wait_mdio_idle();
        @(posedge clock);
        check_value("idle irq after frame", 1'b1, interrupt);
        axi_write(REG_INT_ENABLE, 32'h1 << INT_PHY_BIT);
        check_value("phy irq low", 1'b0, interrupt);
        mdio_int <= 1'b1;
        wait_interrupt(1'b1);
        check_value("phy irq high", 1'b1, interrupt);
        axi_read(REG_INT_STATUS, data, 0);
        check_value("phy status set", 1'b1, data[INT_PHY_BIT]);
        mdio_int <= 1'b0;
        wait_interrupt(1'b0);
        check_value("phy irq cleared", 1'b0, interrupt);
        axi_read(REG_INT_STATUS, data, 0);
        check_value("phy status clear", 1'b0, data[INT_PHY_BIT]);
        take_random(4, rand_value);
        status_vector <= 16'h1 << rand_value[3:0];
        axi_write(REG_INT_ENABLE, 32'h1 << rand_value[3:0]);
        check_value("status irq", 1'b1, interrupt);
        status_vector <= '0;
        repeat (2) @(posedge clock);
        check_value("status irq cleared", 1'b0, interrupt);
        end_test();

        $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/eth_csr_pkg.sv
src/mdio_pkg.sv
src/mdio_req_if.sv
src/eth_mgmt_regs.sv
src/mdio_master.sv
src/eth_mgmt_top.sv
sim/mdio_phy_model.sv
sim/tb_eth_mgmt.sv
